//--- list.f
+incdir+rtl
rtl/core_pkg.sv
rtl/ifu.sv
rtl/idu.sv
rtl/exu.sv
rtl/lsu.sv
rtl/wbu.sv
rtl/core_top.sv
tb/tb_core.sv

//--- Bender.yml
package:
  name: rv32_mini_core

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/core_pkg.sv
      - rtl/ifu.sv
      - rtl/idu.sv
      - rtl/exu.sv
      - rtl/lsu.sv
      - rtl/wbu.sv
      - rtl/core_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/tb_core.sv

//--- tb/tb_core.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module tb_core import core_pkg::*; ();

  localparam int    CLK_PERIOD  = 40;
  localparam int    N_INSTR     = 200;
  localparam int    DMEM_WORDS  = 64;
  localparam word_t DMEM_BASE   = 32'h0001_0100; // lui 0x10 plus addi 0x100
  localparam word_t EBREAK      = 32'h0010_0073;
  localparam int    WATCHDOG_NS = (N_INSTR * 10 + 30) * CLK_PERIOD;

  logic     clk;
  logic     rst_n;
  logic     imem_req;
  word_t    imem_addr;
  word_t    imem_rdata;
  logic     dmem_req;
  logic     dmem_we;
  word_t    dmem_addr;
  word_t    dmem_wdata;
  word_t    dmem_rdata;
  logic     commit_valid;
  word_t    commit_pc;
  reg_idx_t commit_rd;
  word_t    commit_data;
  logic     halted;

  word_t prog [N_INSTR];
  word_t dmem [DMEM_WORDS];

  // reference ISA state
  word_t m_pc;
  word_t m_regs [`CORE_NREGS];
  word_t m_dmem [DMEM_WORDS];
  logic  model_halted;
  int    commits;

  // memory model side
  logic  fetch_hit;
  word_t fetch_at;
  logic  read_hit;
  word_t read_at;
  word_t st_addr_q [$];
  word_t st_data_q [$];

  // expected commit
  word_t    e_pc;
  reg_idx_t e_rd;
  word_t    e_data;
  word_t    e_next; // also the next fetch address
  logic     e_store;
  word_t    e_saddr;
  word_t    e_sdata;
  logic     e_halt;

  core_top u_core_top (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic abort_run();
    $display("** FAIL **");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    assert (got === exp) else begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_data_addr(input word_t addr);
    assert (addr >= DMEM_BASE && addr < DMEM_BASE + 4 * DMEM_WORDS && addr[1:0] == 2'b00)
    else begin
      $display("data access at %h falls outside the data array", addr);
      abort_run();
    end
  endtask

  task automatic check_fetch_addr(input word_t addr);
    assert (addr >= `CORE_RESET_PC && addr < `CORE_RESET_PC + 4 * N_INSTR
            && addr[1:0] == 2'b00)
    else begin
      $display("instruction fetch at %h falls outside the program", addr);
      abort_run();
    end
  endtask

  function automatic int prog_index(input word_t pc);
    return int'((pc - `CORE_RESET_PC) >> 2);
  endfunction

  function automatic int word_index(input word_t addr);
    return int'((addr - DMEM_BASE) >> 2);
  endfunction

  // rv32i encodings
  function automatic word_t r_type(input logic [6:0] f7, input reg_idx_t rs2,
                                   input reg_idx_t rs1, input logic [2:0] f3,
                                   input reg_idx_t rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic word_t i_type(input logic [11:0] imm, input reg_idx_t rs1,
                                   input logic [2:0] f3, input reg_idx_t rd,
                                   input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t s_type(input logic [11:0] imm, input reg_idx_t rs2,
                                   input reg_idx_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `OPC_STORE};
  endfunction

  function automatic word_t b_type(input logic [12:0] imm, input reg_idx_t rs2,
                                   input reg_idx_t rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OPC_BRANCH};
  endfunction

  function automatic word_t u_type(input logic [19:0] imm, input reg_idx_t rd);
    return {imm, rd, `OPC_LUI};
  endfunction

  function automatic word_t j_type(input logic [20:0] imm, input reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OPC_JAL};
  endfunction

  function automatic word_t alu_result(input logic [2:0] f3, input logic alt,
                                       input word_t a, input word_t b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return {31'b0, $signed(a) < $signed(b)};
      3'b011:  return {31'b0, a < b};
      3'b100:  return a ^ b;
      3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic build_program();
    int          kind;
    int          maxk;
    int          k;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm;
    logic [19:0] upper;
    logic [12:0] boff;
    logic [20:0] joff;
    prog[0] = u_type(20'h00010, 5'd31);
    prog[1] = i_type(12'h100, 5'd31, 3'b000, 5'd31, `OPC_OP_IMM);
    for (int i = 2; i < N_INSTR - 1; i++) begin
      kind  = $urandom % 12;
      rd    = $urandom % 31; // x31 keeps the data base
      rs1   = $urandom % 32;
      rs2   = $urandom % 32;
      f3    = $urandom % 8;
      alt   = $urandom % 2;
      imm   = $urandom;
      upper = $urandom;
      maxk  = (N_INSTR - 1 - i < 4) ? N_INSTR - 1 - i : 4; // never past ebreak
      k     = 1 + $urandom % maxk;
      boff  = 4 * k;
      joff  = 4 * k;
      case (kind)
        0, 1, 2, 3:
          prog[i] = r_type((alt && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'b0,
                           rs2, rs1, f3, rd, `OPC_OP);
        4, 5, 6: begin
          if (f3 == 3'b001) imm = {7'b0, imm[4:0]};
          else if (f3 == 3'b101) imm = {1'b0, alt, 5'b0, imm[4:0]};
          prog[i] = i_type(imm, rs1, f3, rd, `OPC_OP_IMM);
        end
        7:  prog[i] = u_type(upper, rd);
        8:  prog[i] = s_type(12'(($urandom % 16) * 4), rs2, 5'd31);
        9:  prog[i] = i_type(12'(($urandom % 16) * 4), 5'd31, 3'b010, rd, `OPC_LOAD);
        10: prog[i] = b_type(boff, rs2, rs1, {f3[2], 1'b0, f3[0]});
        default: prog[i] = j_type(joff, rd);
      endcase
    end
    prog[N_INSTR - 1] = EBREAK;
  endtask

  task automatic fill_data();
    word_t addr;
    for (int i = 0; i < DMEM_WORDS; i++) begin
      addr      = DMEM_BASE + 4 * i;
      dmem[i]   = {addr[15:0], addr[31:16]} ^ 32'h6b3c_19e5;
      m_dmem[i] = dmem[i];
    end
    for (int i = 0; i < `CORE_NREGS; i++) m_regs[i] = '0;
    m_pc         = `CORE_RESET_PC;
    e_next       = `CORE_RESET_PC;
    model_halted = 1'b0;
    commits      = 0;
  endtask

  function automatic void ref_step(output word_t o_pc, output reg_idx_t o_rd,
                                   output word_t o_data, output word_t o_next,
                                   output logic o_store, output word_t o_saddr,
                                   output word_t o_sdata, output logic o_halt);
    word_t      ins;
    word_t      a;
    word_t      b;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_j;
    word_t      val;
    reg_idx_t   rd;
    logic [2:0] f3;
    logic       wr;
    logic       taken;
    ins   = prog[prog_index(m_pc)];
    rd    = ins[11:7];
    f3    = ins[14:12];
    a     = m_regs[ins[19:15]];
    b     = m_regs[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
    val     = '0;
    wr      = 1'b0;
    taken   = 1'b0;
    o_store = 1'b0;
    o_saddr = '0;
    o_sdata = '0;
    o_halt  = 1'b0;
    o_next  = m_pc + 4;
    case (ins[6:0])
      `OPC_OP: begin
        wr  = 1'b1;
        val = alu_result(f3, ins[30], a, b);
      end
      `OPC_OP_IMM: begin
        wr  = 1'b1;
        val = alu_result(f3, f3 == 3'b101 && ins[30], a, imm_i);
      end
      `OPC_LUI: begin
        wr  = 1'b1;
        val = {ins[31:12], 12'b0};
      end
      `OPC_LOAD: begin
        wr  = (f3 == 3'b010);
        val = m_dmem[word_index(a + imm_i)];
      end
      `OPC_STORE: begin
        if (f3 == 3'b010) begin
          o_store = 1'b1;
          o_saddr = a + imm_s;
          o_sdata = b;
          m_dmem[word_index(o_saddr)] = b;
        end
      end
      `OPC_BRANCH: begin
        case (f3)
          3'b000:  taken = (a == b);
          3'b001:  taken = (a != b);
          3'b100:  taken = ($signed(a) < $signed(b));
          3'b101:  taken = ($signed(a) >= $signed(b));
          default: taken = 1'b0;
        endcase
        if (taken) o_next = m_pc + imm_b;
      end
      `OPC_JAL: begin
        wr     = 1'b1;
        val    = m_pc + 4; // link
        o_next = m_pc + imm_j;
      end
      `OPC_SYSTEM: o_halt = (ins == EBREAK);
      default: ;
    endcase
    o_pc = m_pc;
    if (wr && rd != '0) begin
      m_regs[rd] = val;
      o_rd       = rd;
      o_data     = val;
    end else begin
      o_rd   = '0;
      o_data = '0;
    end
    m_pc = o_next;
  endfunction

  // both memories answer one cycle after the request
  always @(posedge clk) begin
    if (rst_n) begin
      fetch_hit = imem_req;
      fetch_at  = imem_addr;
      read_hit  = dmem_req && !dmem_we;
      read_at   = dmem_addr;
      if (fetch_hit) begin
        check_fetch_addr(fetch_at);
        check_word("imem_addr", fetch_at, e_next);
      end
      if (dmem_req) check_data_addr(dmem_addr);
      if (dmem_req && dmem_we) begin
        dmem[word_index(dmem_addr)] = dmem_wdata;
        st_addr_q.push_back(dmem_addr);
        st_data_q.push_back(dmem_wdata);
      end
      #1;
      if (fetch_hit) imem_rdata = prog[prog_index(fetch_at)];
      if (read_hit) dmem_rdata = dmem[word_index(read_at)];
    end
  end

  // compare each commit with the model
  always @(negedge clk) begin
    if (rst_n === 1'b1 && commit_valid === 1'b1) begin
      assert (!model_halted) else begin
        $display("a commit appeared after ebreak had committed");
        abort_run();
      end
      ref_step(e_pc, e_rd, e_data, e_next, e_store, e_saddr, e_sdata, e_halt);
      commits++;
      check_word("commit_pc", commit_pc, e_pc);
      check_word("commit_rd", {27'b0, commit_rd}, {27'b0, e_rd});
      check_word("commit_data", commit_data, e_data);
      check_word("halted", {31'b0, halted}, {31'b0, e_halt});
      if (e_store) begin
        assert (st_addr_q.size() == 1) else begin
          $display("store at %h committed without exactly one data write", e_pc);
          abort_run();
        end
        check_word("dmem_addr", st_addr_q.pop_front(), e_saddr);
        check_word("dmem_wdata", st_data_q.pop_front(), e_sdata);
      end else begin
        assert (st_addr_q.size() == 0) else begin
          $display("data write seen for the non-store at %h", e_pc);
          abort_run();
        end
      end
      if (e_halt) model_halted = 1'b1;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the core stopped committing after %0d commits", commits);
    abort_run();
  end

  initial begin
    rst_n      = 1'b0;
    imem_rdata = '0;
    dmem_rdata = '0;
    void'($urandom(32'ha31bd9e6));
    build_program();
    fill_data();

    @(posedge clk);
    @(negedge clk);
    check_word("commit_valid", {31'b0, commit_valid}, '0);
    check_word("dmem_req", {31'b0, dmem_req}, '0);
    check_word("halted", {31'b0, halted}, '0);
    check_word("imem_req", {31'b0, imem_req}, '0);
    @(posedge clk);
    #1 rst_n = 1'b1;

    // first fetch one cycle after reset release
    @(posedge clk);
    @(negedge clk);
    check_word("imem_req", {31'b0, imem_req}, 32'd1);
    check_word("imem_addr", imem_addr, `CORE_RESET_PC);

    while (halted !== 1'b1) @(negedge clk);
    repeat (20) begin
      @(negedge clk);
      check_word("commit_valid", {31'b0, commit_valid}, '0);
      check_word("imem_req", {31'b0, imem_req}, '0);
      check_word("halted", {31'b0, halted}, 32'd1);
    end

    if (model_halted) begin
      $display("%0d instructions committed", commits);
      $display("** PASS **");
      $finish;
    end else begin
      $display("halted rose before the model reached ebreak");
      abort_run();
    end
  end

endmodule

//--- rtl/core_top.sv
`timescale 1ns/1ps

module core_top import core_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  output logic     imem_req,
  output word_t    imem_addr,
  input  word_t    imem_rdata,
  output logic     dmem_req,
  output logic     dmem_we,
  output word_t    dmem_addr,
  output word_t    dmem_wdata,
  input  word_t    dmem_rdata,
  output logic     commit_valid,
  output word_t    commit_pc,
  output reg_idx_t commit_rd,
  output word_t    commit_data,
  output logic     halted
);

  // fetch to decode
  logic     if_valid;
  word_t    instr, if_pc;

  // decode to execute, plus register reads
  reg_idx_t rs1, rs2, rd;
  word_t    rs1_data, rs2_data;
  logic     id_valid, reg_we, mem_re, mem_we, is_halt;
  word_t    op_a, op_b, store_data, imm, id_pc;
  alu_op_t  alu_op;
  br_op_t   br_op;

  // execute to memory
  logic     ex_valid, ex_reg_we, ex_mem_re, ex_mem_we, ex_is_halt;
  word_t    alu_res, next_pc, ex_store_data, ex_pc;
  reg_idx_t ex_rd;

  // memory to write-back
  logic     ls_valid, ls_reg_we, ls_is_halt;
  word_t    wb_data, ls_next_pc, ls_pc;
  reg_idx_t ls_rd;

  word_t    commit_next_pc; // back to fetch

  ifu u_ifu (.*);
  idu u_idu (.*);
  exu u_exu (.*);
  lsu u_lsu (.*);
  wbu u_wbu (.*);

endmodule

//--- rtl/wbu.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module wbu import core_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     ls_valid,
  input  word_t    wb_data,
  input  word_t    ls_next_pc,
  input  word_t    ls_pc,
  input  reg_idx_t ls_rd,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  input  logic     ls_reg_we,
  input  logic     ls_is_halt,
  output word_t    rs1_data,
  output word_t    rs2_data,
  output logic     commit_valid,
  output word_t    commit_next_pc,
  output word_t    commit_pc,
  output word_t    commit_data,
  output reg_idx_t commit_rd,
  output logic     halted
);

  word_t regs [`CORE_NREGS];

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1]; // x0 hardwired
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `CORE_NREGS; i++) regs[i] <= '0;
      commit_valid <= 1'b0;
      halted       <= 1'b0;
    end else begin
      if (ls_valid && ls_reg_we && ls_rd != '0) regs[ls_rd] <= wb_data;
      commit_valid <= ls_valid;
      if (ls_valid && ls_is_halt) halted <= 1'b1; // sticky
    end
  end

  // commit report
  always_ff @(posedge clk) begin
    if (ls_valid) begin
      commit_pc      <= ls_pc;
      commit_next_pc <= ls_next_pc;
      commit_rd      <= ls_reg_we ? ls_rd : '0;
      commit_data    <= ls_reg_we ? wb_data : '0;
    end
  end

endmodule

//--- rtl/lsu.sv
`timescale 1ns/1ps

module lsu import core_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     ex_valid,
  input  word_t    alu_res,
  input  word_t    next_pc,
  input  word_t    ex_store_data,
  input  word_t    ex_pc,
  input  reg_idx_t ex_rd,
  input  logic     ex_reg_we,
  input  logic     ex_mem_re,
  input  logic     ex_mem_we,
  input  logic     ex_is_halt,
  input  word_t    dmem_rdata,
  output logic     dmem_req,
  output logic     dmem_we,
  output word_t    dmem_addr,
  output word_t    dmem_wdata,
  output logic     ls_valid,
  output word_t    wb_data,
  output word_t    ls_next_pc,
  output word_t    ls_pc,
  output reg_idx_t ls_rd,
  output logic     ls_reg_we,
  output logic     ls_is_halt
);

  logic load_wait; // read data arrives this cycle

  // request goes out in the ex_valid cycle
  assign dmem_req   = ex_valid && (ex_mem_re || ex_mem_we);
  assign dmem_we    = ex_valid && ex_mem_we;
  assign dmem_addr  = alu_res;
  assign dmem_wdata = ex_store_data;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      load_wait  <= 1'b0;
      ls_valid   <= 1'b0;
      ls_reg_we  <= 1'b0;
      ls_is_halt <= 1'b0;
    end else begin
      load_wait <= ex_valid && ex_mem_re;
      ls_valid  <= (ex_valid && !ex_mem_re) || load_wait;
      if (ex_valid) begin
        ls_reg_we  <= ex_reg_we;
        ls_is_halt <= ex_is_halt;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid) begin
      wb_data    <= alu_res;
      ls_next_pc <= next_pc;
      ls_pc      <= ex_pc;
      ls_rd      <= ex_rd;
    end
    if (load_wait) wb_data <= dmem_rdata;
  end

  a_we_has_req: assert property (@(posedge clk) disable iff (!rst_n)
    dmem_we |-> dmem_req);

endmodule

//--- rtl/exu.sv
`timescale 1ns/1ps

module exu import core_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     id_valid,
  input  word_t    op_a,
  input  word_t    op_b,
  input  word_t    store_data,
  input  word_t    imm,
  input  word_t    id_pc,
  input  alu_op_t  alu_op,
  input  br_op_t   br_op,
  input  reg_idx_t rd,
  input  logic     reg_we,
  input  logic     mem_re,
  input  logic     mem_we,
  input  logic     is_halt,
  output logic     ex_valid,
  output word_t    alu_res,
  output word_t    next_pc,
  output word_t    ex_store_data,
  output word_t    ex_pc,
  output reg_idx_t ex_rd,
  output logic     ex_reg_we,
  output logic     ex_mem_re,
  output logic     ex_mem_we,
  output logic     ex_is_halt
);

  word_t alu_out;
  word_t pc_plus4;
  logic  taken;

  assign pc_plus4 = id_pc + 32'd4;

  always_comb begin
    case (alu_op)
      alu_sub:    alu_out = op_a - op_b;
      alu_and:    alu_out = op_a & op_b;
      alu_or:     alu_out = op_a | op_b;
      alu_xor:    alu_out = op_a ^ op_b;
      alu_sll:    alu_out = op_a << op_b[4:0];
      alu_srl:    alu_out = op_a >> op_b[4:0];
      alu_sra:    alu_out = word_t'($signed(op_a) >>> op_b[4:0]);
      alu_slt:    alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
      alu_sltu:   alu_out = {31'b0, op_a < op_b};
      alu_pass_b: alu_out = op_b;
      default:    alu_out = op_a + op_b;
    endcase
  end

  // rs2 arrives on store_data for branches
  always_comb begin
    case (br_op)
      br_eq:   taken = (op_a == store_data);
      br_ne:   taken = (op_a != store_data);
      br_lt:   taken = ($signed(op_a) < $signed(store_data));
      br_ge:   taken = ($signed(op_a) >= $signed(store_data));
      br_jal:  taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_valid   <= 1'b0;
      ex_reg_we  <= 1'b0;
      ex_mem_re  <= 1'b0;
      ex_mem_we  <= 1'b0;
      ex_is_halt <= 1'b0;
    end else begin
      ex_valid <= id_valid;
      if (id_valid) begin
        ex_reg_we  <= reg_we;
        ex_mem_re  <= mem_re;
        ex_mem_we  <= mem_we;
        ex_is_halt <= is_halt;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (id_valid) begin
      alu_res       <= (br_op == br_jal) ? pc_plus4 : alu_out; // link value
      next_pc       <= taken ? id_pc + imm : pc_plus4;
      ex_store_data <= store_data;
      ex_pc         <= id_pc;
      ex_rd         <= rd;
    end
  end

  a_single_issue: assert property (@(posedge clk) disable iff (!rst_n)
    ex_valid |=> !ex_valid);

endmodule

//--- rtl/idu.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module idu import core_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     if_valid,
  input  word_t    instr,
  input  word_t    if_pc,
  input  word_t    rs1_data,
  input  word_t    rs2_data,
  output reg_idx_t rs1,
  output reg_idx_t rs2,
  output logic     id_valid,
  output word_t    op_a,
  output word_t    op_b,
  output word_t    store_data,
  output word_t    imm,
  output word_t    id_pc,
  output alu_op_t  alu_op,
  output br_op_t   br_op,
  output reg_idx_t rd,
  output logic     reg_we,
  output logic     mem_re,
  output logic     mem_we,
  output logic     is_halt
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  reg_idx_t   dec_rd;
  word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
  word_t      dec_b, dec_imm;
  alu_op_t    f3_alu, dec_alu;
  br_op_t     dec_br;
  logic       dec_we, dec_re, dec_wr, dec_halt;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign dec_rd = instr[11:7];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    case (funct3)
      3'b000:  f3_alu = (opcode == `OPC_OP && instr[30]) ? alu_sub : alu_add;
      3'b001:  f3_alu = alu_sll;
      3'b010:  f3_alu = alu_slt;
      3'b011:  f3_alu = alu_sltu;
      3'b100:  f3_alu = alu_xor;
      3'b101:  f3_alu = instr[30] ? alu_sra : alu_srl; // srai shares bit 30
      3'b110:  f3_alu = alu_or;
      default: f3_alu = alu_and;
    endcase
  end

  always_comb begin
    dec_alu  = alu_add;
    dec_br   = br_none;
    dec_b    = rs2_data;
    dec_imm  = imm_i;
    dec_we   = 1'b0;
    dec_re   = 1'b0;
    dec_wr   = 1'b0;
    dec_halt = 1'b0;
    case (opcode)
      `OPC_OP: begin
        dec_alu = f3_alu;
        dec_we  = 1'b1;
      end
      `OPC_OP_IMM: begin
        dec_alu = f3_alu;
        dec_b   = imm_i;
        dec_we  = 1'b1;
      end
      `OPC_LUI: begin
        dec_alu = alu_pass_b;
        dec_b   = imm_u;
        dec_imm = imm_u;
        dec_we  = 1'b1;
      end
      `OPC_LOAD: begin
        dec_b  = imm_i;
        dec_re = (funct3 == 3'b010); // lw only
        dec_we = (funct3 == 3'b010);
      end
      `OPC_STORE: begin
        dec_b   = imm_s;
        dec_imm = imm_s;
        dec_wr  = (funct3 == 3'b010);
      end
      `OPC_BRANCH: begin
        dec_imm = imm_b;
        case (funct3)
          3'b000:  dec_br = br_eq;
          3'b001:  dec_br = br_ne;
          3'b100:  dec_br = br_lt;
          3'b101:  dec_br = br_ge;
          default: dec_br = br_none;
        endcase
      end
      `OPC_JAL: begin
        dec_imm = imm_j;
        dec_br  = br_jal;
        dec_we  = 1'b1;
      end
      `OPC_SYSTEM: dec_halt = (instr[31:7] == 25'h0002000); // ebreak
      default: ; // no-op
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      id_valid <= 1'b0;
      reg_we   <= 1'b0;
      mem_re   <= 1'b0;
      mem_we   <= 1'b0;
      is_halt  <= 1'b0;
      br_op    <= br_none;
    end else begin
      id_valid <= if_valid;
      if (if_valid) begin
        reg_we  <= dec_we && (dec_rd != '0);
        mem_re  <= dec_re;
        mem_we  <= dec_wr;
        is_halt <= dec_halt;
        br_op   <= dec_br;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (if_valid) begin
      op_a       <= rs1_data;
      op_b       <= dec_b;
      store_data <= rs2_data; // store value and branch rhs
      imm        <= dec_imm;
      id_pc      <= if_pc;
      alu_op     <= dec_alu;
      rd         <= dec_rd;
    end
  end

endmodule

//--- rtl/ifu.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module ifu import core_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  commit_valid,
  input  logic  halted,
  input  word_t commit_next_pc,
  input  word_t imem_rdata,
  output logic  imem_req,
  output word_t imem_addr,
  output logic  if_valid,
  output word_t instr,
  output word_t if_pc
);

  fetch_state_t state;
  word_t        pc;
  logic         booted;  // first fetch issued
  logic         rsp_due; // imem_rdata valid this cycle

  assign imem_addr = pc;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= f_idle;
      pc       <= `CORE_RESET_PC;
      booted   <= 1'b0;
      imem_req <= 1'b0;
      rsp_due  <= 1'b0;
      if_valid <= 1'b0;
    end else begin
      imem_req <= 1'b0;
      if_valid <= 1'b0;
      rsp_due  <= imem_req;
      case (state)
        f_idle: begin
          if (halted) begin
            state <= f_halt;
          end else if (!booted || commit_valid) begin
            imem_req <= 1'b1;
            state    <= f_wait;
            booted   <= 1'b1;
            if (booted) pc <= commit_next_pc;
          end
        end
        f_wait: begin
          if (rsp_due) begin
            if_valid <= 1'b1;
            state    <= f_idle;
          end
        end
        f_halt: ; // parked until reset
        default: state <= f_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == f_wait && rsp_due) begin
      instr <= imem_rdata;
      if_pc <= pc;
    end
  end

  a_no_fetch_halted: assert property (@(posedge clk) disable iff (!rst_n)
    state == f_halt |-> !imem_req);

endmodule

//--- rtl/core_pkg.sv
package core_pkg;

  typedef logic [31:0] word_t;    // data, address and instruction
  typedef logic [4:0]  reg_idx_t;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_slt,
    alu_sltu,
    alu_pass_b // lui
  } alu_op_t;

  // br_jal is always taken
  typedef enum logic [2:0] {
    br_none,
    br_eq,
    br_ne,
    br_lt,
    br_ge,
    br_jal
  } br_op_t;

  typedef enum logic [1:0] {
    f_idle,
    f_wait,
    f_halt
  } fetch_state_t;

endpackage

//--- rtl/core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// first fetch address after reset
`define CORE_RESET_PC 32'h8000_0000

// integer register file depth
`define CORE_NREGS 32

// rv32i major opcodes, instr[6:0]
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LUI     7'b0110111
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_BRANCH  7'b1100011
`define OPC_JAL     7'b1101111
`define OPC_SYSTEM  7'b1110011 // only ebreak decoded

`endif
